// File: src/wd_ram_pkg.sv
package wd_ram_pkg;

    // ----------------------------------------
    // RAM geometry
    // ----------------------------------------

    // One watchdog state word per queue
    localparam int DEPTH = 64;

    // Word address width covers exactly DEPTH entries
    localparam int AWIDTH = 6;

    localparam int DWIDTH = 32;

    // The APB port is byte addressed and only the low word indices are populated
    localparam int APB_AWIDTH = 12;

    // ----------------------------------------
    // Request and bus bundles
    // ----------------------------------------

    // One RAM access with separate read and write addresses so that a read and a write
    // can share a cycle
    typedef struct packed {
        logic              re;
        logic              we;
        logic [AWIDTH-1:0] raddr;
        logic [AWIDTH-1:0] waddr;
        logic [DWIDTH-1:0] wdata;
    } mem_req_t;

    // Signals driven by the APB requester
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_AWIDTH-1:0] paddr;
        logic [DWIDTH-1:0]     pwdata;
    } apb_req_t;

    // Signals returned by the APB completer
    typedef struct packed {
        logic [DWIDTH-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// File: src/wd_pf_init.sv
`timescale 1ns/1ns

module wd_pf_init
    import wd_ram_pkg::*;
(
      input  logic     clk
    , input  logic     rst_n
    , output mem_req_t init_req
    , output logic     init_busy
    , output logic     init_done
);

    // Next word to clear while the sweep runs
    logic [AWIDTH-1:0] addr_q;
    logic              busy_q;
    logic              done_q;

    // ----------------------------------------
    // Sweep control
    // ----------------------------------------

    // Address 0 is cleared in the first cycle out of reset, after which one word is
    // cleared per cycle until the last address has been written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (busy_q) begin
            addr_q <= addr_q + 1'b1;
            if (addr_q == AWIDTH'(DEPTH - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // The sweeper only ever writes zeros
    // The write enable stays low while reset is held
    assign init_req.re    = 1'b0;
    assign init_req.raddr = '0;
    assign init_req.we    = busy_q & rst_n;
    assign init_req.waddr = addr_q;
    assign init_req.wdata = '0;

    // Busy covers the reset cycles too so no other client slips in ahead of address 0
    assign init_busy = ~done_q;
    assign init_done = done_q;

    // Once finished the sweeper stays done and quiet until the next reset
    a_quiet_after_done : assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done && !init_req.we);

endmodule

// File: src/wd_cfg_apb.sv
`timescale 1ns/1ns

module wd_cfg_apb
    import wd_ram_pkg::*;
(
      input  logic              clk
    , input  logic              rst_n
    , input  apb_req_t          apb_req
    , output apb_rsp_t          apb_rsp
    , output mem_req_t          cfg_req
    , input  logic              cfg_gnt
    , input  logic [DWIDTH-1:0] cfg_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RD_WAIT,
        ST_RESP
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic              access;
    logic              out_of_range;
    logic [AWIDTH-1:0] word_addr;
    logic              mem_op;
    logic [DWIDTH-1:0] prdata_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    assign access       = apb_req.psel & apb_req.penable;
    // Anything above the populated word range gets an error response
    assign out_of_range = |apb_req.paddr[APB_AWIDTH-1:AWIDTH+2];
    assign word_addr    = apb_req.paddr[AWIDTH+1:2];

    // The RAM request is held through the access phase until the access block grants it
    assign mem_op = (state_q == ST_REQ) & access & ~out_of_range;

    assign cfg_req.re    = mem_op & ~apb_req.pwrite;
    assign cfg_req.we    = mem_op & apb_req.pwrite;
    assign cfg_req.raddr = word_addr;
    assign cfg_req.waddr = word_addr;
    assign cfg_req.wdata = apb_req.pwdata;

    // ----------------------------------------
    // Transfer FSM
    // ----------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // A setup cycle starts a transfer
                if (apb_req.psel && !apb_req.penable) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (access && out_of_range) begin
                    state_d = ST_IDLE;
                end else if (mem_op && cfg_gnt) begin
                    state_d = apb_req.pwrite ? ST_IDLE : ST_RD_WAIT;
                end else if (!apb_req.psel) begin
                    state_d = ST_IDLE;
                end
            end
            // RAM read data shows up here and is captured for the response
            ST_RD_WAIT: state_d = ST_RESP;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_RD_WAIT) begin
            prdata_q <= cfg_rdata;
        end
    end

    // pready is a single cycle pulse and prdata is zero except on a completed read
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b0;
        apb_rsp.pslverr = 1'b0;
        if (state_q == ST_REQ && access && out_of_range) begin
            apb_rsp.pready  = 1'b1;
            apb_rsp.pslverr = 1'b1;
        end else if (mem_op && cfg_gnt && apb_req.pwrite) begin
            // Writes complete in the cycle the RAM takes them
            apb_rsp.pready = 1'b1;
        end else if (state_q == ST_RESP) begin
            apb_rsp.pready = 1'b1;
            apb_rsp.prdata = prdata_q;
        end
    end

    // Protocol checks on the requester side
    a_penable_needs_psel : assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

    // Address holds from setup until the completing access cycle
    a_paddr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(apb_req.paddr));

endmodule

// File: src/wd_ram_access.sv
`timescale 1ns/1ns

module wd_ram_access
    import wd_ram_pkg::*;
(
      input  logic              clk
    , input  logic              rst_n
    , input  mem_req_t          init_req
    , input  logic              init_busy
    , input  mem_req_t          func_req
    , input  mem_req_t          cfg_req
    , output logic              cfg_gnt
    , output mem_req_t          ram_req
    , input  logic [DWIDTH-1:0] ram_rdata
    , output logic [DWIDTH-1:0] func_rdata
    , output logic [DWIDTH-1:0] cfg_rdata
);

    logic func_v;
    logic cfg_v;

    assign func_v = func_req.re | func_req.we;
    assign cfg_v  = cfg_req.re | cfg_req.we;

    // ----------------------------------------
    // Request select
    // ----------------------------------------

    // While the sweep is pending the sweeper owns the port outright and other
    // requests are dropped
    // Functional traffic comes next and config only gets the leftover cycles
    always_comb begin
        ram_req = '0;
        cfg_gnt = 1'b0;
        if (init_busy) begin
            ram_req = init_req;
        end else if (func_v) begin
            ram_req = func_req;
        end else if (cfg_v) begin
            ram_req = cfg_req;
            cfg_gnt = 1'b1;
        end
    end

    // ----------------------------------------
    // Read data return
    // ----------------------------------------

    // Each reader knows when its own data is due so the RAM output fans out to both
    assign func_rdata = ram_rdata;
    assign cfg_rdata  = ram_rdata;

    // The sweeper never reads so a read during the sweep would mean a functional or
    // config request leaked through
    a_no_read_in_init : assert property (@(posedge clk) disable iff (!rst_n)
        init_busy |-> !ram_req.re);

endmodule

// File: src/wd_state_ram.sv
`timescale 1ns/1ns

module wd_state_ram
    import wd_ram_pkg::*;
(
      input  logic              clk
    , input  mem_req_t          ram_req
    , output logic [DWIDTH-1:0] ram_rdata
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    logic [DWIDTH-1:0] mem [DEPTH];

    // Contents are only ever set by writes and the init sweep clears them after reset
    always_ff @(posedge clk) begin
        if (ram_req.we) begin
            mem[ram_req.waddr] <= ram_req.wdata;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Nonblocking update means a same-address read sees the word before this
    // cycle's write
    // The output register keeps its last value on idle cycles
    always_ff @(posedge clk) begin
        if (ram_req.re) begin
            ram_rdata <= mem[ram_req.raddr];
        end
    end

endmodule

// File: src/wd_ram_top.sv
`timescale 1ns/1ns

module wd_ram_top
    import wd_ram_pkg::*;
(
      input  logic              clk
    , input  logic              rst_n
    , input  mem_req_t          func_req
    , output logic              func_ready
    , output logic [DWIDTH-1:0] func_rdata
    , input  apb_req_t          apb_req
    , output apb_rsp_t          apb_rsp
);

    mem_req_t          init_req;
    logic              init_busy;
    logic              init_done;
    mem_req_t          cfg_req;
    logic              cfg_gnt;
    logic [DWIDTH-1:0] cfg_rdata;
    mem_req_t          ram_req;
    logic [DWIDTH-1:0] ram_rdata;

    // The functional client may start once every word has been cleared
    assign func_ready = init_done;

    // ----------------------------------------
    // Request sources
    // ----------------------------------------

    wd_pf_init u_pf_init (
          .clk       (clk)
        , .rst_n     (rst_n)
        , .init_req  (init_req)
        , .init_busy (init_busy)
        , .init_done (init_done)
    );

    wd_cfg_apb u_cfg_apb (
          .clk       (clk)
        , .rst_n     (rst_n)
        , .apb_req   (apb_req)
        , .apb_rsp   (apb_rsp)
        , .cfg_req   (cfg_req)
        , .cfg_gnt   (cfg_gnt)
        , .cfg_rdata (cfg_rdata)
    );

    // ----------------------------------------
    // Shared RAM port
    // ----------------------------------------

    wd_ram_access u_ram_access (
          .clk        (clk)
        , .rst_n      (rst_n)
        , .init_req   (init_req)
        , .init_busy  (init_busy)
        , .func_req   (func_req)
        , .cfg_req    (cfg_req)
        , .cfg_gnt    (cfg_gnt)
        , .ram_req    (ram_req)
        , .ram_rdata  (ram_rdata)
        , .func_rdata (func_rdata)
        , .cfg_rdata  (cfg_rdata)
    );

    wd_state_ram u_state_ram (
          .clk       (clk)
        , .ram_req   (ram_req)
        , .ram_rdata (ram_rdata)
    );

endmodule

// File: dv/tb_wd_ram_top.sv
`timescale 1ns/1ns

module tb_wd_ram_top
    import wd_ram_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int FUNC_OPS     = 300;
    localparam int APB_OPS      = 24;
    localparam int OOR_OPS      = 8;
    localparam int CONT_ROUNDS  = 4;
    localparam int BURST_LEN    = 12;
    // The whole sequence runs for roughly 1700 cycles
    localparam int TIMEOUT_CYCLES = 6000;
    localparam logic [31:0] SEED  = 32'h5022db35;

    logic              clk = 1'b0;
    logic              rst_n;
    mem_req_t          func_req;
    logic              func_ready;
    logic [DWIDTH-1:0] func_rdata;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    // Reference copy of the RAM contents
    logic [DWIDTH-1:0] ref_mem [DEPTH];

    int                cyc = 0;
    int                rel_cyc = 0;
    int                apb_done_cyc = 0;
    int                burst_end_cyc = 0;
    logic              rd_pend = 1'b0;
    logic [DWIDTH-1:0] rd_exp;
    logic              apb_err_exp;

    always #2 clk = ~clk;

    wd_ram_top u_wd_ram_top (
          .clk        (clk)
        , .rst_n      (rst_n)
        , .func_req   (func_req)
        , .func_ready (func_ready)
        , .func_rdata (func_rdata)
        , .apb_req    (apb_req)
        , .apb_rsp    (apb_rsp)
    );

    // ----------------------------------------
    // Checking helpers
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [DWIDTH-1:0] ref_read(input logic [AWIDTH-1:0] addr);
        return ref_mem[addr];
    endfunction

    // Cycle count since time zero also bounds the run
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Comparing process
    // ----------------------------------------

    // Everything is sampled mid-cycle where both inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst_n) begin
            // The sweep clears every word before any client gets through
            for (int i = 0; i < DEPTH; i++) begin
                ref_mem[i] = '0;
            end
            rd_pend = 1'b0;
        end else begin
            if (rd_pend) begin
                check_value("func_rdata", func_rdata, rd_exp);
                rd_pend = 1'b0;
            end
            // Read-first, so the expected word is taken before this cycle's write
            if (func_ready && func_req.re) begin
                rd_exp  = ref_read(func_req.raddr);
                rd_pend = 1'b1;
            end
            if (func_ready && func_req.we) begin
                ref_mem[func_req.waddr] = func_req.wdata;
            end
            if (apb_rsp.pready) begin
                check_value("pready_in_access", 32'(apb_req.psel && apb_req.penable), 32'd1);
                // Word index is paddr[7:2] and anything in paddr[11:8] is out of range
                apb_err_exp = |apb_req.paddr[11:8];
                check_value("pslverr", 32'(apb_rsp.pslverr), 32'(apb_err_exp));
                if (!apb_req.pwrite) begin
                    check_value("prdata", apb_rsp.prdata,
                                apb_err_exp ? 32'd0 : ref_read(apb_req.paddr[7:2]));
                end else if (!apb_err_exp) begin
                    ref_mem[apb_req.paddr[7:2]] = apb_req.pwdata;
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        func_req = '0;
        apb_req  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value("func_ready", 32'(func_ready), 32'd0);
        check_value("pready", 32'(apb_rsp.pready), 32'd0);
        check_value("pslverr", 32'(apb_rsp.pslverr), 32'd0);
        rst_n   = 1'b1;
        rel_cyc = cyc;
    endtask

    // The sweep takes exactly one cycle per word
    task automatic wait_init();
        int lat;
        while (!func_ready) begin
            @(negedge clk);
        end
        lat = cyc - rel_cyc;
        check_value("init_latency", 32'(lat), 32'(DEPTH));
    endtask

    // One functional request held for exactly one cycle
    task automatic func_op(input logic re, input logic we, input logic [AWIDTH-1:0] raddr,
                           input logic [AWIDTH-1:0] waddr, input logic [DWIDTH-1:0] wdata);
        @(posedge clk);
        #1;
        func_req.re    = re;
        func_req.we    = we;
        func_req.raddr = raddr;
        func_req.waddr = waddr;
        func_req.wdata = wdata;
    endtask

    task automatic func_idle();
        @(posedge clk);
        #1;
        func_req = '0;
    endtask

    // Setup phase, then access phase held until pready
    task automatic apb_xfer(input logic write, input logic [APB_AWIDTH-1:0] addr,
                            input logic [DWIDTH-1:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        apb_done_cyc = cyc;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read_all();
        for (int i = 0; i < DEPTH; i++) begin
            apb_xfer(1'b0, {4'h0, AWIDTH'(i), 2'b00}, '0);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [31:0]           r;
        logic [AWIDTH-1:0]     ra;
        logic [AWIDTH-1:0]     wa;
        logic [APB_AWIDTH-1:0] pa;
        logic                  apb_wr;
        logic [DWIDTH-1:0]     apb_wd;
        logic [AWIDTH-1:0]     words [APB_OPS];
        rst_n    = 1'b0;
        func_req = '0;
        apb_req  = '0;
        r        = $urandom(SEED);

        // Init sweep, with functional writes during the sweep that must be dropped
        // Word 0 is already cleared by then so a leaked write would stay visible
        reset_dut();
        repeat (3) func_op(1'b0, 1'b1, 6'd0, 6'd0, 32'hdead_beef);
        func_idle();
        wait_init();
        apb_read_all();

        // Same-address read and write in one cycle returns the old word
        func_op(1'b0, 1'b1, 6'd7, 6'd7, 32'h1111_2222);
        func_op(1'b1, 1'b1, 6'd7, 6'd7, 32'h3333_4444);
        func_op(1'b1, 1'b0, 6'd7, 6'd7, '0);
        for (int i = 0; i < FUNC_OPS; i++) begin
            r  = $urandom;
            ra = AWIDTH'($urandom);
            wa = (r[3:0] == 4'h0) ? ra : AWIDTH'($urandom);
            func_op(r[4], r[5], ra, wa, $urandom);
        end
        func_idle();

        // APB writes to random words, then reads of the same words
        for (int i = 0; i < APB_OPS; i++) begin
            words[i] = AWIDTH'($urandom);
            apb_xfer(1'b1, {4'h0, words[i], 2'b00}, $urandom);
        end
        for (int i = 0; i < APB_OPS; i++) begin
            apb_xfer(1'b0, {4'h0, words[i], 2'b00}, '0);
        end

        // Out-of-range transfers, then a read of the aliased word to see it untouched
        for (int i = 0; i < OOR_OPS; i++) begin
            pa = APB_AWIDTH'($urandom);
            if (pa[11:8] == 4'h0) begin
                pa[11:8] = 4'h8;
            end
            apb_xfer(1'b1, pa, $urandom);
            apb_xfer(1'b0, pa, '0);
            apb_xfer(1'b0, {4'h0, pa[7:0]}, '0);
        end

        // APB transfers stall behind a functional burst that never leaves a gap
        for (int k = 0; k < CONT_ROUNDS; k++) begin
            r      = $urandom;
            apb_wr = r[8];
            pa     = {4'h0, AWIDTH'($urandom), 2'b00};
            apb_wd = $urandom;
            fork
                apb_xfer(apb_wr, pa, apb_wd);
                begin
                    for (int i = 0; i < BURST_LEN; i++) begin
                        r = $urandom;
                        func_op(r[0] | ~r[1], r[1], AWIDTH'($urandom),
                                AWIDTH'($urandom), $urandom);
                    end
                    burst_end_cyc = cyc;
                    func_idle();
                end
            join
            check_value("apb_after_burst", 32'(apb_done_cyc > burst_end_cyc), 32'd1);
        end

        // Reset in the middle of traffic sweeps every word back to zero
        for (int i = 0; i < 16; i++) begin
            func_op(1'b0, 1'b1, '0, AWIDTH'($urandom), $urandom | 32'h1);
        end
        func_idle();
        apb_xfer(1'b1, 12'h010, 32'hcafe_f00d);
        reset_dut();
        wait_init();
        for (int i = 0; i < DEPTH; i++) begin
            func_op(1'b1, 1'b0, AWIDTH'(i), '0, '0);
        end
        func_idle();
        apb_read_all();

        repeat (2) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verilog.f
src/wd_ram_pkg.sv
src/wd_pf_init.sv
src/wd_cfg_apb.sv
src/wd_ram_access.sv
src/wd_state_ram.sv
src/wd_ram_top.sv
dv/tb_wd_ram_top.sv

// File: run.sh
#!/bin/sh
# Build the watchdog state RAM testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_wd_ram_top

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_wd_ram_top -f verilog.f -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
    echo "Simulation exited with an error status"
fi

cat "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
